// ==== dv/program_tests.txt ====
// Word 0: test count. Per block: word count then program words / retirement count
// then (rd value) pairs in retire order / end marker 0000e0d0. Unloaded words are WFI
00000006
// Test 1 independent ADDI pairs
00000004  00500093 00700113 00b00193 fff00213
00000005  01 00000005  02 00000007  03 0000000b  04 ffffffff  00 00000000
0000e0d0
// Test 2 slot 1 reads slot 0 destination
00000003  00a00293 00328313 006283b3
00000004  05 0000000a  06 0000000d  07 00000017  00 00000000
0000e0d0
// Test 3 ADD and SUB chain across groups
00000006  06400093 01e00113 402081b3 00118233 404102b3 005280b3
00000007  01 00000064  02 0000001e  03 00000046  04 000000aa  05 ffffff74  01 fffffee8
          00 00000000
0000e0d0
// Test 4 writes to x0 and reads of x0
00000004  00900013 00400413 008004b3 00000533
00000005  00 00000009  08 00000004  09 00000004  0a 00000000  00 00000000
0000e0d0
// Test 5 WFI in slot 1 stops everything after it
00000004  00100593 10500073 00200613 00300693
00000002  0b 00000001  00 00000000
0000e0d0
// Test 6 LUI and XOR retire as no-ops
00000005  00600713 12345737 00170793 00f7c833 00e78833
00000006  0e 00000006  00 00000000  0f 00000007  00 00000000  10 0000000d  00 00000000
0000e0d0

// ==== flist.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/reg_file.sv
src/dispatch_stage.sv
src/execute_stage.sv
src/retire_stage.sv
src/superscalar_core.sv
dv/core_assert.sv
dv/core_tb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run all programs, check sim.log"
	@echo "  clean  remove the build directory and sim.log"

obj_dir/Vcore_tb: flist.f $(wildcard src/*.sv dv/*.sv)
	verilator --binary --timing --assert -f flist.f --top-module core_tb -o Vcore_tb

test: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb 2>&1 | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" sim.log; then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== dv/core_tb.sv ====
// Testbench for the two-way core
// Runs each program of the tests file and checks the retired rd/value stream
`timescale 1ns/1ps

module core_tb;

	localparam int          MEM_WORDS    = 64;
	localparam int          FILE_WORDS   = 512;
	localparam int          RESET_CYCLES = 4;
	localparam int          TAIL_CYCLES  = 8;
	localparam logic [31:0] END_MARK     = 32'h0000_e0d0;

	logic                                                    clock;
	logic                                                    rst_n;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            imem_addr;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0]      imem_data;
	logic [pipe_pkg::WAYS-1:0]                               retire_valid;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  retire_rd;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            retire_value;
	logic                                                    halt;

	// Raw tests file and instruction memory model
	logic [31:0]                    file_words [FILE_WORDS];
	logic [isa_pkg::INST_WIDTH-1:0] imem [MEM_WORDS];
	int                             test_pos [$];

	// Retirements of the running test, oldest first
	logic [isa_pkg::REG_ADDR_WIDTH-1:0] got_rd [$];
	logic [isa_pkg::XLEN-1:0]           got_value [$];

	int cycle_count = 0;
	int cycle_limit = 0;
	int error_count = 0;
	int pass_count  = 0;
	int fail_count  = 0;

	superscalar_core u_dut (
		.clock        (clock),
		.rst_n        (rst_n),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value),
		.halt         (halt)
	);

	// 20 ns period
	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Memory model and watchdog
	//////////////////////////////////////////////////////////////////////

	// Words outside the 64-word array read as WFI too
	function automatic logic [isa_pkg::INST_WIDTH-1:0] fetch_word(input logic [31:0] addr);
		if (addr < 32'(MEM_WORDS * 4)) begin
			return imem[addr[7:2]];
		end
		return isa_pkg::INST_WFI;
	endfunction

	// Address is stable by the falling edge
	always @(negedge clock) begin
		for (int i = 0; i < pipe_pkg::WAYS; i++) begin
			imem_data[i] <= fetch_word(imem_addr[i]);
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: no result after %0d cycles, the core never halted", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tests file walk and one test run
	//////////////////////////////////////////////////////////////////////

	// Finds each block start, checks end markers, sums the cycle budget
	task automatic scan_tests(output bit ok);
		int n_tests;
		int n_words;
		int n_ret;
		int p;
		int budget;
		ok      = 1'b1;
		n_tests = file_words[0];
		p       = 1;
		budget  = 0;
		if (n_tests <= 0) begin
			ok = 1'b0;
		end
		for (int t = 0; t < n_tests && ok; t++) begin
			test_pos.push_back(p);
			n_words = file_words[p];
			if (n_words < 0 || n_words > MEM_WORDS) begin
				ok = 1'b0;
			end
			p     = p + 1 + n_words;
			n_ret = (p < FILE_WORDS) ? int'(file_words[p]) : 0;
			p     = p + 1 + 2 * n_ret;
			if (p >= FILE_WORDS || file_words[p] != END_MARK) begin
				ok = 1'b0;
			end
			p      = p + 1;
			budget = budget + 10 * n_words + 40;
		end
		cycle_limit = budget;
	endtask

	task automatic run_test(input int test_num, input int pos);
		int          n_words;
		int          n_ret;
		int          n_check;
		int          errors_at_start;
		bit          halted;
		logic [31:0] exp_rd;
		logic [31:0] exp_value;
		errors_at_start = error_count;
		// Program loads while reset is held
		@(negedge clock);
		rst_n = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = isa_pkg::INST_WFI;
		end
		n_words = file_words[pos];
		for (int i = 0; i < n_words; i++) begin
			imem[i] = file_words[pos + 1 + i];
		end
		n_ret = file_words[pos + 1 + n_words];
		got_rd.delete();
		got_value.delete();
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		// Slot 0 is the older one
		halted = 1'b0;
		while (!halted) begin
			@(negedge clock);
			for (int i = 0; i < pipe_pkg::WAYS; i++) begin
				if (retire_valid[i]) begin
					got_rd.push_back(retire_rd[i]);
					got_value.push_back(retire_value[i]);
				end
			end
			halted = halt;
		end
		// Quiet after the WFI, halt held
		repeat (TAIL_CYCLES) begin
			@(negedge clock);
			if (retire_valid != '0) begin
				$display("ERROR %0t test %0d: retire_valid %b after halt", $time, test_num,
					retire_valid);
				error_count++;
			end
			if (!halt) begin
				$display("ERROR %0t test %0d: halt dropped before reset", $time, test_num);
				error_count++;
			end
		end
		if (got_rd.size() != n_ret) begin
			$display("ERROR %0t test %0d: expected %0d retirements, got %0d", $time, test_num,
				n_ret, got_rd.size());
			error_count++;
		end
		n_check = (got_rd.size() < n_ret) ? got_rd.size() : n_ret;
		for (int k = 0; k < n_check; k++) begin
			exp_rd    = file_words[pos + 2 + n_words + 2 * k];
			exp_value = file_words[pos + 3 + n_words + 2 * k];
			if (got_rd[k] != exp_rd[isa_pkg::REG_ADDR_WIDTH-1:0] || got_value[k] != exp_value) begin
				$display("ERROR %0t test %0d retirement %0d: expected x%0d = %h, got x%0d = %h",
					$time, test_num, k, exp_rd, exp_value, got_rd[k], got_value[k]);
				error_count++;
			end
		end
		if (error_count == errors_at_start) begin
			pass_count++;
			$display("Test %0d passed, %0d retirements", test_num, got_rd.size());
		end else begin
			fail_count++;
			$display("Test %0d failed with %0d errors", test_num, error_count - errors_at_start);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		bit file_ok;
		clock     = 1'b0;
		rst_n     = 1'b0;
		imem_data = '0;
		$readmemh("dv/program_tests.txt", file_words);
		scan_tests(file_ok);
		if (file_ok) begin
			foreach (test_pos[t]) begin
				run_test(t + 1, test_pos[t]);
			end
		end else begin
			$display("Tests file dv/program_tests.txt is malformed, no test was run");
			error_count++;
		end
		$display("Done: %0d tests, %0d passed, %0d failed, %0d errors", test_pos.size(),
			pass_count, fail_count, error_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== dv/core_assert.sv ====
// Concurrent checks on the core's outside ports
// Bound into every superscalar_core instance
`timescale 1ns/1ps

module core_assert (
	input  logic                                          clock,
	input  logic                                          rst_n,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]  imem_addr,
	input  logic [pipe_pkg::WAYS-1:0]                     retire_valid,
	input  logic                                          halt,
	input  logic [pipe_pkg::WAYS-1:0]                     buf_valid,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]  buf_pc
);

	// Sticky halt, only reset clears it
	halt_sticky: assert property (@(posedge clock) disable iff (!rst_n) !$fell(halt))
		else $error("halt fell while the core was out of reset");

	// Older slot always retires first
	slot1_after_slot0: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid[1] |-> retire_valid[0])
		else $error("slot 1 retired without slot 0");

	// Fetch group is two consecutive words
	group_addr: assert property (@(posedge clock)
		imem_addr[1] == imem_addr[0] + isa_pkg::INST_BYTES)
		else $error("second fetch address is not the first plus one word");

	// Buffer keeps program order across shifts and refills
	buf_order: assert property (@(posedge clock) disable iff (!rst_n)
		buf_valid[1] |-> (buf_pc[1] == buf_pc[0] + isa_pkg::INST_BYTES))
		else $error("buffer slot 1 address does not follow slot 0");

endmodule

bind superscalar_core core_assert u_core_assert (
	.clock        (clock),
	.rst_n        (rst_n),
	.imem_addr    (imem_addr),
	.retire_valid (retire_valid),
	.halt         (halt),
	.buf_valid    (buf_valid),
	.buf_pc       (buf_pc)
);

// ==== src/superscalar_core.sv ====
// Top of the two-way in-order core
// Fetch, buffer, dispatch, execute and retire around one register file
`timescale 1ns/1ps

module superscalar_core (
	input  logic                                                    clock,
	input  logic                                                    rst_n,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            imem_addr,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0]      imem_data,
	output logic [pipe_pkg::WAYS-1:0]                               retire_valid,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  retire_rd,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            retire_value,
	output logic                                                    halt
);

	// Front end
	logic [isa_pkg::XLEN-1:0]                               fetch_pc;
	pipe_pkg::dispatch_count_t                              fill_count;
	pipe_pkg::dispatch_count_t                              disp_count;
	logic [pipe_pkg::WAYS-1:0]                              buf_valid;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0]     buf_inst;
	// Slot address, watched by simulation for ordering
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           buf_pc;

	// Register file ports
	logic [2*pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0] rf_addr;
	logic [2*pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           rf_data;
	logic [pipe_pkg::WAYS-1:0]                                rf_wr_en;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]   rf_wr_addr;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]             rf_wr_data;

	// Dispatch to execute
	logic [pipe_pkg::WAYS-1:0]                              ex_valid;
	pipe_pkg::alu_op_t [pipe_pkg::WAYS-1:0]                 ex_op;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0] ex_rd;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           ex_a;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           ex_b;
	logic [pipe_pkg::WAYS-1:0]                              ex_wfi;

	// Execute to retire
	logic [pipe_pkg::WAYS-1:0]                              wb_valid;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0] wb_rd;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           wb_value;
	logic [pipe_pkg::WAYS-1:0]                              wb_wfi;

	//////////////////////////////////////////////////////////////////////
	// Front end
	//////////////////////////////////////////////////////////////////////

	fetch_stage u_fetch (
		.clock      (clock),
		.rst_n      (rst_n),
		.fill_count (fill_count),
		.fetch_pc   (fetch_pc),
		.imem_addr  (imem_addr)
	);

	fetch_buffer u_fetch_buffer (
		.clock      (clock),
		.rst_n      (rst_n),
		.fetch_pc   (fetch_pc),
		.imem_data  (imem_data),
		.disp_count (disp_count),
		.fill_count (fill_count),
		.buf_valid  (buf_valid),
		.buf_inst   (buf_inst),
		.buf_pc     (buf_pc)
	);

	//////////////////////////////////////////////////////////////////////
	// Dispatch and register file
	//////////////////////////////////////////////////////////////////////

	dispatch_stage u_dispatch (
		.clock        (clock),
		.rst_n        (rst_n),
		.buf_valid    (buf_valid),
		.buf_inst     (buf_inst),
		.rf_addr      (rf_addr),
		.rf_data      (rf_data),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.disp_count   (disp_count),
		.ex_valid     (ex_valid),
		.ex_op        (ex_op),
		.ex_rd        (ex_rd),
		.ex_a         (ex_a),
		.ex_b         (ex_b),
		.ex_wfi       (ex_wfi)
	);

	reg_file u_reg_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.rd_addr (rf_addr),
		.rd_data (rf_data),
		.wr_en   (rf_wr_en),
		.wr_addr (rf_wr_addr),
		.wr_data (rf_wr_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Back end
	//////////////////////////////////////////////////////////////////////

	execute_stage u_execute (
		.clock    (clock),
		.rst_n    (rst_n),
		.ex_valid (ex_valid),
		.ex_op    (ex_op),
		.ex_rd    (ex_rd),
		.ex_a     (ex_a),
		.ex_b     (ex_b),
		.ex_wfi   (ex_wfi),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_value (wb_value),
		.wb_wfi   (wb_wfi)
	);

	retire_stage u_retire (
		.clock        (clock),
		.rst_n        (rst_n),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_value     (wb_value),
		.wb_wfi       (wb_wfi),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value),
		.rf_wr_en     (rf_wr_en),
		.rf_wr_addr   (rf_wr_addr),
		.rf_wr_data   (rf_wr_data),
		.halt         (halt)
	);

endmodule

// ==== src/retire_stage.sv ====
// Retire register, register file writes and the sticky halt
// Its outputs also clear the dispatch scoreboard
`timescale 1ns/1ps

module retire_stage (
	input  logic                                                    clock,
	input  logic                                                    rst_n,
	input  logic [pipe_pkg::WAYS-1:0]                               wb_valid,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  wb_rd,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            wb_value,
	input  logic [pipe_pkg::WAYS-1:0]                               wb_wfi,
	output logic [pipe_pkg::WAYS-1:0]                               retire_valid,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  retire_rd,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            retire_value,
	output logic [pipe_pkg::WAYS-1:0]                               rf_wr_en,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  rf_wr_addr,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            rf_wr_data,
	output logic                                                    halt
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid <= '0;
			retire_rd    <= '0;
			retire_value <= '0;
			halt         <= 1'b0;
		end else begin
			retire_valid <= wb_valid;
			retire_rd    <= wb_rd;
			retire_value <= wb_value;
			// Once set only reset lowers it
			if (|(wb_valid & wb_wfi)) begin
				halt <= 1'b1;
			end
		end
	end

	// Write back every valid result except those aimed at x0
	always_comb begin
		for (int i = 0; i < pipe_pkg::WAYS; i++) begin
			rf_wr_en[i]   = retire_valid[i] && (retire_rd[i] != '0);
			rf_wr_addr[i] = retire_rd[i];
			rf_wr_data[i] = retire_value[i];
		end
	end

endmodule

// ==== src/execute_stage.sv ====
// One-cycle ALU per slot, results registered toward retire
// PASS_NONE slots come out as x0 with value zero
`timescale 1ns/1ps

module execute_stage (
	input  logic                                                    clock,
	input  logic                                                    rst_n,
	input  logic [pipe_pkg::WAYS-1:0]                               ex_valid,
	input  pipe_pkg::alu_op_t [pipe_pkg::WAYS-1:0]                  ex_op,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  ex_rd,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            ex_a,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            ex_b,
	input  logic [pipe_pkg::WAYS-1:0]                               ex_wfi,
	output logic [pipe_pkg::WAYS-1:0]                               wb_valid,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  wb_rd,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            wb_value,
	output logic [pipe_pkg::WAYS-1:0]                               wb_wfi
);

	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           alu_out;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0] alu_rd;

	// Add or subtract, anything else drops its destination
	always_comb begin
		for (int i = 0; i < pipe_pkg::WAYS; i++) begin
			alu_rd[i] = ex_rd[i];
			case (ex_op[i])
				pipe_pkg::ALU_ADD: alu_out[i] = ex_a[i] + ex_b[i];
				pipe_pkg::ALU_SUB: alu_out[i] = ex_a[i] - ex_b[i];
				default: begin
					alu_out[i] = '0;
					alu_rd[i]  = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= '0;
			wb_rd    <= '0;
			wb_value <= '0;
			wb_wfi   <= '0;
		end else begin
			wb_valid <= ex_valid;
			wb_rd    <= alu_rd;
			wb_value <= alu_out;
			wb_wfi   <= ex_valid & ex_wfi;
		end
	end

endmodule

// ==== src/dispatch_stage.sv ====
// Decode and in-order dispatch of up to two instructions per cycle
// A busy-register scoreboard holds back hazards until the writer retires
`timescale 1ns/1ps

module dispatch_stage (
	input  logic                                                      clock,
	input  logic                                                      rst_n,
	input  logic [pipe_pkg::WAYS-1:0]                                 buf_valid,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0]        buf_inst,
	output logic [2*pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  rf_addr,
	input  logic [2*pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            rf_data,
	input  logic [pipe_pkg::WAYS-1:0]                                 retire_valid,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]    retire_rd,
	output pipe_pkg::dispatch_count_t                                 disp_count,
	output logic [pipe_pkg::WAYS-1:0]                                 ex_valid,
	output pipe_pkg::alu_op_t [pipe_pkg::WAYS-1:0]                    ex_op,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]    ex_rd,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]              ex_a,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]              ex_b,
	output logic [pipe_pkg::WAYS-1:0]                                 ex_wfi
);

	// Decoded fields per slot
	logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0] rd_f, rs1_f, rs2_f;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]           imm;
	pipe_pkg::alu_op_t [pipe_pkg::WAYS-1:0]                 op;
	logic [pipe_pkg::WAYS-1:0] use_rs1, use_rs2, writes, is_wfi, free, go;
	logic                      dep_on_slot0;

	// Scoreboard and the post-WFI lock
	logic [isa_pkg::N_REGS-1:0] busy;
	logic                       wfi_seen;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < pipe_pkg::WAYS; i++) begin
			rd_f[i]    = buf_inst[i][11:7];
			rs1_f[i]   = buf_inst[i][19:15];
			rs2_f[i]   = buf_inst[i][24:20];
			// I-type immediate, sign extended
			imm[i]     = {{20{buf_inst[i][31]}}, buf_inst[i][31:20]};
			is_wfi[i]  = (buf_inst[i] == isa_pkg::INST_WFI);
			op[i]      = pipe_pkg::ALU_PASS_NONE;
			use_rs1[i] = 1'b0;
			use_rs2[i] = 1'b0;
			// ADD and SUB need funct3 zero and a known funct7
			if ((buf_inst[i][6:0] == isa_pkg::OPCODE_OP) && (buf_inst[i][14:12] == 3'b000)) begin
				if (buf_inst[i][31:25] == isa_pkg::FUNCT7_SUB) begin
					op[i] = pipe_pkg::ALU_SUB;
				end else if (buf_inst[i][31:25] == 7'b0000000) begin
					op[i] = pipe_pkg::ALU_ADD;
				end
				use_rs1[i] = (op[i] != pipe_pkg::ALU_PASS_NONE);
				use_rs2[i] = (op[i] != pipe_pkg::ALU_PASS_NONE);
			end else if ((buf_inst[i][6:0] == isa_pkg::OPCODE_OP_IMM) &&
					(buf_inst[i][14:12] == 3'b000)) begin
				// ADDI
				op[i]      = pipe_pkg::ALU_ADD;
				use_rs1[i] = 1'b1;
			end
			// No-ops and x0 writes never claim a register
			writes[i] = (op[i] != pipe_pkg::ALU_PASS_NONE) && (rd_f[i] != '0);
			free[i]   = !(use_rs1[i] && busy[rs1_f[i]]) && !(use_rs2[i] && busy[rs2_f[i]]) &&
				!(writes[i] && busy[rd_f[i]]);
			// Operand reads, rs2 port unused by ADDI
			rf_addr[2*i]   = rs1_f[i];
			rf_addr[2*i+1] = rs2_f[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Dispatch decision
	//////////////////////////////////////////////////////////////////////

	// Slot 1 against slot 0 destination, RAW and WAW
	assign dep_on_slot0 = writes[0] && ((use_rs1[1] && (rs1_f[1] == rd_f[0])) ||
		(use_rs2[1] && (rs2_f[1] == rd_f[0])) || (writes[1] && (rd_f[1] == rd_f[0])));

	// Strictly in order, slot 1 only behind slot 0
	assign go[0] = buf_valid[0] && !wfi_seen && free[0];
	assign go[1] = go[0] && buf_valid[1] && free[1] && !dep_on_slot0 && !is_wfi[0];

	always_comb begin
		case (go)
			2'b11:   disp_count = 2'd2;
			2'b01:   disp_count = 2'd1;
			default: disp_count = 2'd0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Scoreboard and dispatch/execute register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= '0;
			wfi_seen <= 1'b0;
			ex_valid <= '0;
			ex_op    <= {pipe_pkg::WAYS{pipe_pkg::ALU_PASS_NONE}};
			ex_rd    <= '0;
			ex_a     <= '0;
			ex_b     <= '0;
			ex_wfi   <= '0;
		end else begin
			// Free on the retire write edge
			for (int i = 0; i < pipe_pkg::WAYS; i++) begin
				if (retire_valid[i]) begin
					busy[retire_rd[i]] <= 1'b0;
				end
			end
			// Claim destinations of what leaves now
			for (int i = 0; i < pipe_pkg::WAYS; i++) begin
				if (go[i] && writes[i]) begin
					busy[rd_f[i]] <= 1'b1;
				end
				ex_valid[i] <= go[i];
				ex_op[i]    <= op[i];
				ex_rd[i]    <= rd_f[i];
				ex_a[i]     <= rf_data[2*i];
				ex_b[i]     <= use_rs2[i] ? rf_data[2*i+1] : imm[i];
				ex_wfi[i]   <= go[i] && is_wfi[i];
			end
			// Nothing dispatches after a WFI until reset
			if ((go[0] && is_wfi[0]) || (go[1] && is_wfi[1])) begin
				wfi_seen <= 1'b1;
			end
		end
	end

endmodule

// ==== src/reg_file.sv ====
// Integer register file, four combinational reads and two writes
// Reads 2i and 2i+1 are rs1 and rs2 of slot i
`timescale 1ns/1ps

module reg_file (
	input  logic                                                      clock,
	input  logic                                                      rst_n,
	input  logic [2*pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]  rd_addr,
	output logic [2*pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]            rd_data,
	input  logic [pipe_pkg::WAYS-1:0]                                 wr_en,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::REG_ADDR_WIDTH-1:0]    wr_addr,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]              wr_data
);

	logic [isa_pkg::N_REGS-1:0][isa_pkg::XLEN-1:0] regs;

	// Writes land on the edge, new value readable next cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else begin
			// Later slot overrides on a shared address
			for (int i = 0; i < pipe_pkg::WAYS; i++) begin
				if (wr_en[i] && (wr_addr[i] != '0)) begin
					regs[wr_addr[i]] <= wr_data[i];
				end
			end
		end
	end

	// x0 reads as zero
	always_comb begin
		for (int i = 0; i < 2 * pipe_pkg::WAYS; i++) begin
			rd_data[i] = (rd_addr[i] == '0) ? '0 : regs[rd_addr[i]];
		end
	end

endmodule

// ==== src/fetch_buffer.sv ====
// Two-slot buffer between fetch and dispatch
// Dispatched slots leave from the front, survivors move up, fetch words fill the rest
`timescale 1ns/1ps

module fetch_buffer (
	input  logic                                                clock,
	input  logic                                                rst_n,
	input  logic [isa_pkg::XLEN-1:0]                            fetch_pc,
	input  logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0]  imem_data,
	input  pipe_pkg::dispatch_count_t                           disp_count,
	output pipe_pkg::dispatch_count_t                           fill_count,
	output logic [pipe_pkg::WAYS-1:0]                           buf_valid,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0]  buf_inst,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]        buf_pc
);

	logic [pipe_pkg::WAYS-1:0][isa_pkg::INST_WIDTH-1:0] nxt_inst;
	logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0]       nxt_pc;

	// Next contents of each slot
	always_comb begin
		int held;
		held = 0;
		// Valid slots are packed from slot 0
		for (int i = 0; i < pipe_pkg::WAYS; i++) begin
			if (buf_valid[i]) begin
				held++;
			end
		end
		// Slots that stay behind after dispatch
		held = held - int'(disp_count);
		fill_count = pipe_pkg::dispatch_count_t'(pipe_pkg::WAYS - held);
		for (int i = 0; i < pipe_pkg::WAYS; i++) begin
			if (i < held) begin
				// Shift a held slot forward past the dispatched ones
				nxt_inst[i] = buf_inst[i + int'(disp_count)];
				nxt_pc[i]   = buf_pc[i + int'(disp_count)];
			end else begin
				// Free slot takes the next fetch word in order
				nxt_inst[i] = imem_data[i - held];
				nxt_pc[i]   = fetch_pc + (i - held) * isa_pkg::INST_BYTES;
			end
		end
	end

	// Memory answers every cycle so all slots are full after the first edge
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			buf_valid <= '0;
			buf_inst  <= '0;
			buf_pc    <= '0;
		end else begin
			buf_valid <= '1;
			buf_inst  <= nxt_inst;
			buf_pc    <= nxt_pc;
		end
	end

endmodule

// ==== src/fetch_stage.sv ====
// Program counter of the front end
// Requests two consecutive words and steps by what the buffer took
`timescale 1ns/1ps

module fetch_stage (
	input  logic                                         clock,
	input  logic                                         rst_n,
	input  pipe_pkg::dispatch_count_t                    fill_count,
	output logic [isa_pkg::XLEN-1:0]                     fetch_pc,
	output logic [pipe_pkg::WAYS-1:0][isa_pkg::XLEN-1:0] imem_addr
);

	logic [isa_pkg::XLEN-1:0] pc_step;

	// Accepted words times the instruction size
	assign pc_step = isa_pkg::INST_BYTES *
		{{(isa_pkg::XLEN - $bits(fill_count)){1'b0}}, fill_count};

	// PC holds on a full stall and moves one word on a partial one
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			fetch_pc <= pipe_pkg::RESET_PC;
		end else begin
			fetch_pc <= fetch_pc + pc_step;
		end
	end

	// Group addresses in program order
	for (genvar i = 0; i < pipe_pkg::WAYS; i++) begin : g_addr
		assign imem_addr[i] = fetch_pc + i * isa_pkg::INST_BYTES;
	end

endmodule

// ==== src/pipe_pkg.sv ====
// Pipeline shape and the small types passed between stages
// Stage modules reach these through scoped names

package pipe_pkg;

	// Two slots per fetch and dispatch group
	localparam int WAYS = 2;

	// First fetch address out of reset
	localparam logic [isa_pkg::XLEN-1:0] RESET_PC = '0;

	// Slots taken in one cycle, 0 to 2
	typedef logic [1:0] dispatch_count_t;

	// ALU function per slot
	// PASS_NONE covers WFI and every unsupported opcode
	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_NONE
	} alu_op_t;

endpackage

// ==== src/isa_pkg.sv ====
// Encoding constants for the RISC-V integer subset the core decodes
// Shared by fetch, dispatch and the register file through scoped names

package isa_pkg;

	// Datapath and instruction widths
	localparam int XLEN           = 32;
	localparam int INST_WIDTH     = 32;

	// Integer register file shape
	localparam int REG_ADDR_WIDTH = 5;
	localparam int N_REGS         = 32;

	// Major opcodes of register-register and register-immediate ALU ops
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

	// funct7 for SUB, ADD uses all zero
	localparam logic [6:0] FUNCT7_SUB    = 7'b0100000;

	// Whole WFI word, matched exactly
	localparam logic [INST_WIDTH-1:0] INST_WFI = 32'h1050_0073;

	// Byte step between neighbouring instructions
	localparam logic [XLEN-1:0] INST_BYTES = 4;

endpackage
